//--- include/arbiter_cfg.svh
/*
 * Input arbiter configuration
 * Queue count, stream widths and per-queue FIFO depth
 */

`ifndef ARBITER_CFG_SVH
`define ARBITER_CFG_SVH

// Number of receive queues merged onto the output
`define ARB_NUM_QUEUES 4

// AXI-Stream payload widths
`define ARB_DATA_WIDTH 32
`define ARB_STRB_WIDTH (`ARB_DATA_WIDTH / 8)
`define ARB_USER_WIDTH 16

// log2 of the entries held by each input FIFO
`define ARB_FIFO_DEPTH_BITS 2

`endif

//--- source/arbiter_pkg.sv
/*
 * Input arbiter types
 * Stream beat layout, queue number and packet counter value
 */

`default_nettype none

`include "arbiter_cfg.svh"

package arbiter_pkg;

   // One AXI-Stream beat as stored in a queue FIFO, 53 bits
   typedef struct packed {
      logic                       tlast;
      logic [`ARB_USER_WIDTH-1:0] tuser;
      logic [`ARB_STRB_WIDTH-1:0] tstrb;
      logic [`ARB_DATA_WIDTH-1:0] tdata;
   } axis_beat_t;

   // Queue number
   typedef logic [$clog2(`ARB_NUM_QUEUES)-1:0] queue_idx_t;

   // Packets sent, wraps at 16 bits
   typedef logic [15:0] pkt_count_t;

endpackage

`default_nettype wire

//--- source/small_fifo.sv
/*
 * Small synchronous FIFO
 * Circular buffer for any payload type, registered read port,
 * empty and nearly-full flags
 */

`default_nettype none

module small_fifo #(
   parameter type T          = logic [7:0],
   parameter int  DEPTH_BITS = 2
) (
   input  wire  axi_aclk,
   input  wire  axi_resetn,

   input  wire T din,
   input  wire  wr_en,
   input  wire  rd_en,

   output T     dout,
   output logic empty,
   output logic nearly_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   T                      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   assign full        = (count == (DEPTH_BITS+1)'(DEPTH));
   assign empty       = (count == '0);
   // High with one free slot left, and stays high when full
   assign nearly_full = (count >= (DEPTH_BITS+1)'(DEPTH - 1));

   // Overflowing writes and underflowing reads are dropped
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   ////////////////////////////////////////////////////////////////////
   // Storage and read register
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   // Popped entry stays on dout until the next pop
   always_ff @(posedge axi_aclk) begin
      if (do_rd) begin
         dout <= mem[rd_ptr];
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Pointers and fill count
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/rr_arb_fsm.sv
/*
 * Round-robin packet scheduler
 * Visits the queue FIFOs in turn, forwards one whole packet per visit
 * and registers each beat onto the output stream
 */

`default_nettype none

`include "arbiter_cfg.svh"

module rr_arb_fsm
   import arbiter_pkg::*;
(
   input  wire                              axi_aclk,
   input  wire                              axi_resetn,

   // Queue FIFO heads and flags
   input  wire axis_beat_t [`ARB_NUM_QUEUES-1:0] head,
   input  wire [`ARB_NUM_QUEUES-1:0]         empty,
   input  wire                              m_axis_tready,
   output logic [`ARB_NUM_QUEUES-1:0]        rd_en,

   // Registered output beat
   output axis_beat_t                       out_beat,
   output logic                             out_valid,

   // End-of-packet report to the counters
   output logic                             pkt_sent,
   output queue_idx_t                       pkt_queue
);

   typedef enum logic {
      IDLE,
      SENDING
   } state_t;

   state_t     state;
   state_t     state_next;
   queue_idx_t cur_queue;
   queue_idx_t cur_queue_next;
   queue_idx_t cur_queue_plus1;
   axis_beat_t head_sel;
   logic       emit;

   // Next queue in turn, wrapping after the last one
   assign cur_queue_plus1 = (cur_queue == queue_idx_t'(`ARB_NUM_QUEUES - 1)) ?
                            '0 : cur_queue + 1'b1;

   assign head_sel = head[cur_queue];

   ////////////////////////////////////////////////////////////////////
   // Next-state logic
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      state_next     = state;
      cur_queue_next = cur_queue;
      rd_en          = '0;
      emit           = 1'b0;

      case (state)
         // Walk the queues until one holds data
         IDLE: begin
            if (m_axis_tready) begin
               if (empty[cur_queue]) begin
                  cur_queue_next = cur_queue_plus1;
               end else begin
                  rd_en[cur_queue] = 1'b1;
                  state_next       = SENDING;
               end
            end
         end

         // Head holds the popped beat of the current packet
         SENDING: begin
            if (m_axis_tready) begin
               if (head_sel.tlast) begin
                  emit           = 1'b1;
                  state_next     = IDLE;
                  cur_queue_next = cur_queue_plus1;
               end else if (!empty[cur_queue]) begin
                  // Forward this beat and fetch the one behind it
                  emit             = 1'b1;
                  rd_en[cur_queue] = 1'b1;
               end
               // else the queue starved mid-packet, hold the beat
            end
         end

         default: begin
            state_next = IDLE;
         end
      endcase
   end

   // Counter sees the packet end on the edge that registers tlast
   assign pkt_sent  = emit && head_sel.tlast;
   assign pkt_queue = cur_queue;

   ////////////////////////////////////////////////////////////////////
   // State and output registers
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state     <= IDLE;
         cur_queue <= '0;
         out_valid <= 1'b0;
         out_beat  <= '0;
      end else begin
         state     <= state_next;
         cur_queue <= cur_queue_next;
         out_valid <= emit;
         if (emit) begin
            out_beat <= head_sel;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/pkt_counter.sv
/*
 * Packet counters
 * One wrapping count of sent packets per queue, cleared by software
 */

`default_nettype none

`include "arbiter_cfg.svh"

module pkt_counter
   import arbiter_pkg::*;
(
   input  wire                                axi_aclk,
   input  wire                                axi_resetn,

   input  wire                                pkt_sent,
   input  wire queue_idx_t                    pkt_queue,
   input  wire                                stats_clear,

   output pkt_count_t [`ARB_NUM_QUEUES-1:0]    pkt_count
);

   pkt_count_t [`ARB_NUM_QUEUES-1:0] count_next;

   always_comb begin
      count_next = pkt_count;
      // Clear wins over a packet ending in the same cycle
      if (stats_clear) begin
         count_next = '0;
      end else if (pkt_sent) begin
         count_next[pkt_queue] = pkt_count[pkt_queue] + 1'b1;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         pkt_count <= '0;
      end else begin
         pkt_count <= count_next;
      end
   end

endmodule

`default_nettype wire

//--- source/input_arbiter.sv
/*
 * Input arbiter top level
 * Merges four AXI-Stream receive queues into one output stream,
 * one whole packet at a time, and counts packets per queue
 */

`default_nettype none

`include "arbiter_cfg.svh"

module input_arbiter
   import arbiter_pkg::*;
(
   input  wire                               axi_aclk,
   input  wire                               axi_resetn,

   // Receive queue 0
   input  wire [`ARB_DATA_WIDTH-1:0]          s_axis_tdata_0,
   input  wire [`ARB_STRB_WIDTH-1:0]          s_axis_tstrb_0,
   input  wire [`ARB_USER_WIDTH-1:0]          s_axis_tuser_0,
   input  wire                               s_axis_tvalid_0,
   input  wire                               s_axis_tlast_0,
   output logic                              s_axis_tready_0,

   // Receive queue 1
   input  wire [`ARB_DATA_WIDTH-1:0]          s_axis_tdata_1,
   input  wire [`ARB_STRB_WIDTH-1:0]          s_axis_tstrb_1,
   input  wire [`ARB_USER_WIDTH-1:0]          s_axis_tuser_1,
   input  wire                               s_axis_tvalid_1,
   input  wire                               s_axis_tlast_1,
   output logic                              s_axis_tready_1,

   // Receive queue 2
   input  wire [`ARB_DATA_WIDTH-1:0]          s_axis_tdata_2,
   input  wire [`ARB_STRB_WIDTH-1:0]          s_axis_tstrb_2,
   input  wire [`ARB_USER_WIDTH-1:0]          s_axis_tuser_2,
   input  wire                               s_axis_tvalid_2,
   input  wire                               s_axis_tlast_2,
   output logic                              s_axis_tready_2,

   // Receive queue 3
   input  wire [`ARB_DATA_WIDTH-1:0]          s_axis_tdata_3,
   input  wire [`ARB_STRB_WIDTH-1:0]          s_axis_tstrb_3,
   input  wire [`ARB_USER_WIDTH-1:0]          s_axis_tuser_3,
   input  wire                               s_axis_tvalid_3,
   input  wire                               s_axis_tlast_3,
   output logic                              s_axis_tready_3,

   // Merged output stream, ready is a look-ahead permission
   output logic [`ARB_DATA_WIDTH-1:0]         m_axis_tdata,
   output logic [`ARB_STRB_WIDTH-1:0]         m_axis_tstrb,
   output logic [`ARB_USER_WIDTH-1:0]         m_axis_tuser,
   output logic                              m_axis_tvalid,
   output logic                              m_axis_tlast,
   input  wire                               m_axis_tready,

   // Statistics
   input  wire                               stats_clear,
   output pkt_count_t [`ARB_NUM_QUEUES-1:0]   pkt_count
);

   axis_beat_t [`ARB_NUM_QUEUES-1:0] in_beat;
   logic [`ARB_NUM_QUEUES-1:0]       in_valid;
   axis_beat_t [`ARB_NUM_QUEUES-1:0] fifo_dout;
   logic [`ARB_NUM_QUEUES-1:0]       fifo_empty;
   logic [`ARB_NUM_QUEUES-1:0]       nearly_full;
   logic [`ARB_NUM_QUEUES-1:0]       rd_en;
   axis_beat_t                       out_beat;
   logic                             out_valid;
   logic                             pkt_sent;
   queue_idx_t                       pkt_queue;

   ////////////////////////////////////////////////////////////////////
   // Input packing
   ////////////////////////////////////////////////////////////////////

   assign in_beat[0] = '{tlast: s_axis_tlast_0, tuser: s_axis_tuser_0,
                         tstrb: s_axis_tstrb_0, tdata: s_axis_tdata_0};
   assign in_beat[1] = '{tlast: s_axis_tlast_1, tuser: s_axis_tuser_1,
                         tstrb: s_axis_tstrb_1, tdata: s_axis_tdata_1};
   assign in_beat[2] = '{tlast: s_axis_tlast_2, tuser: s_axis_tuser_2,
                         tstrb: s_axis_tstrb_2, tdata: s_axis_tdata_2};
   assign in_beat[3] = '{tlast: s_axis_tlast_3, tuser: s_axis_tuser_3,
                         tstrb: s_axis_tstrb_3, tdata: s_axis_tdata_3};

   assign in_valid = {s_axis_tvalid_3, s_axis_tvalid_2, s_axis_tvalid_1, s_axis_tvalid_0};

   // Ready drops once three entries are held
   assign s_axis_tready_0 = !nearly_full[0];
   assign s_axis_tready_1 = !nearly_full[1];
   assign s_axis_tready_2 = !nearly_full[2];
   assign s_axis_tready_3 = !nearly_full[3];

   ////////////////////////////////////////////////////////////////////
   // Queue FIFOs, scheduler and counters
   ////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < `ARB_NUM_QUEUES; i++) begin : g_queue
      small_fifo #(
         .T          (axis_beat_t),
         .DEPTH_BITS (`ARB_FIFO_DEPTH_BITS)
      ) u_fifo (
         .axi_aclk    (axi_aclk),
         .axi_resetn  (axi_resetn),
         .din         (in_beat[i]),
         .wr_en       (in_valid[i] && !nearly_full[i]),
         .rd_en       (rd_en[i]),
         .dout        (fifo_dout[i]),
         .empty       (fifo_empty[i]),
         .nearly_full (nearly_full[i])
      );
   end

   rr_arb_fsm u_fsm (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .head          (fifo_dout),
      .empty         (fifo_empty),
      .m_axis_tready (m_axis_tready),
      .rd_en         (rd_en),
      .out_beat      (out_beat),
      .out_valid     (out_valid),
      .pkt_sent      (pkt_sent),
      .pkt_queue     (pkt_queue)
   );

   pkt_counter u_counter (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .pkt_sent    (pkt_sent),
      .pkt_queue   (pkt_queue),
      .stats_clear (stats_clear),
      .pkt_count   (pkt_count)
   );

   // Output unpacking
   assign m_axis_tdata  = out_beat.tdata;
   assign m_axis_tstrb  = out_beat.tstrb;
   assign m_axis_tuser  = out_beat.tuser;
   assign m_axis_tlast  = out_beat.tlast;
   assign m_axis_tvalid = out_valid;

endmodule

`default_nettype wire

//--- testbench/tb_input_arbiter.sv
/*
 * Input arbiter testbench
 * Drives the four receive queues, keeps expected beats per queue and
 * a round-robin pointer model, and checks the merged output stream
 */

`default_nettype none

`include "arbiter_cfg.svh"

module tb_input_arbiter
   import arbiter_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NQ             = `ARB_NUM_QUEUES;
   localparam int TIMEOUT_CYCLES = 4000;

   logic                        axi_aclk      = 1'b0;
   logic                        axi_resetn    = 1'b0;
   axis_beat_t                  in_beat [NQ]  = '{default: '0};
   logic [NQ-1:0]               in_valid      = '0;
   logic                        m_axis_tready = 1'b1;
   logic                        stats_clear   = 1'b0;
   wire  [NQ-1:0]               s_ready;
   wire  [`ARB_DATA_WIDTH-1:0]  m_tdata;
   wire  [`ARB_STRB_WIDTH-1:0]  m_tstrb;
   wire  [`ARB_USER_WIDTH-1:0]  m_tuser;
   wire                         m_tvalid;
   wire                         m_tlast;
   pkt_count_t [NQ-1:0]         pkt_count;

   // Reference model state
   axis_beat_t exp_q [NQ][$];
   int         tlast_seen [NQ] = '{default: 0};
   int         ptr         = 0;
   int         cur_src     = 0;
   bit         in_pkt      = 1'b0;
   bit         resync      = 1'b0;
   bit         follow_tag  = 1'b0;
   bit         stream_done = 1'b0;

   integer     seed        = 32'h4500_6348;
   int         cycles      = 0;
   int         checks      = 0;
   int         errors      = 0;
   int         test_errors = 0;
   int         start_beats = 0;
   int         beats_out   = 0;
   string      test_name   = "none";

   always #4 axi_aclk = ~axi_aclk;

   input_arbiter uut (
      .axi_aclk        (axi_aclk),
      .axi_resetn      (axi_resetn),
      .s_axis_tdata_0  (in_beat[0].tdata),
      .s_axis_tstrb_0  (in_beat[0].tstrb),
      .s_axis_tuser_0  (in_beat[0].tuser),
      .s_axis_tvalid_0 (in_valid[0]),
      .s_axis_tlast_0  (in_beat[0].tlast),
      .s_axis_tready_0 (s_ready[0]),
      .s_axis_tdata_1  (in_beat[1].tdata),
      .s_axis_tstrb_1  (in_beat[1].tstrb),
      .s_axis_tuser_1  (in_beat[1].tuser),
      .s_axis_tvalid_1 (in_valid[1]),
      .s_axis_tlast_1  (in_beat[1].tlast),
      .s_axis_tready_1 (s_ready[1]),
      .s_axis_tdata_2  (in_beat[2].tdata),
      .s_axis_tstrb_2  (in_beat[2].tstrb),
      .s_axis_tuser_2  (in_beat[2].tuser),
      .s_axis_tvalid_2 (in_valid[2]),
      .s_axis_tlast_2  (in_beat[2].tlast),
      .s_axis_tready_2 (s_ready[2]),
      .s_axis_tdata_3  (in_beat[3].tdata),
      .s_axis_tstrb_3  (in_beat[3].tstrb),
      .s_axis_tuser_3  (in_beat[3].tuser),
      .s_axis_tvalid_3 (in_valid[3]),
      .s_axis_tlast_3  (in_beat[3].tlast),
      .s_axis_tready_3 (s_ready[3]),
      .m_axis_tdata    (m_tdata),
      .m_axis_tstrb    (m_tstrb),
      .m_axis_tuser    (m_tuser),
      .m_axis_tvalid   (m_tvalid),
      .m_axis_tlast    (m_tlast),
      .m_axis_tready   (m_axis_tready),
      .stats_clear     (stats_clear),
      .pkt_count       (pkt_count)
   );

   //////////////////////////////////////////////////////////////////////
   // Checking helpers
   //////////////////////////////////////////////////////////////////////

   task automatic check_value(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
      checks++;
      assert (act === exp) else begin
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_counts();
      for (int q = 0; q < NQ; q++) begin
         check_value("pkt_count", 64'(tlast_seen[q]), 64'(pkt_count[q]));
      end
   endtask

   // First queue in turn from the pointer that has beats waiting
   function automatic int next_busy_queue(input int from);
      int q;
      for (int i = 0; i < NQ; i++) begin
         q = (from + i) % NQ;
         if (exp_q[q].size() > 0) begin
            return q;
         end
      end
      return -1;
   endfunction

   function automatic bit queues_empty();
      for (int q = 0; q < NQ; q++) begin
         if (exp_q[q].size() > 0) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Monitor sampled between clock edges
   //////////////////////////////////////////////////////////////////////

   always @(negedge axi_aclk) begin : monitor
      axis_beat_t act;
      axis_beat_t exp;
      int         pred;
      if (axi_resetn) begin
         // Beats that the next rising edge accepts
         for (int q = 0; q < NQ; q++) begin
            if (in_valid[q] && s_ready[q]) begin
               exp_q[q].push_back(in_beat[q]);
            end
         end
         if (m_tvalid) begin
            act = '{tlast: m_tlast, tuser: m_tuser, tstrb: m_tstrb, tdata: m_tdata};
            beats_out++;
            if (!in_pkt) begin
               if (follow_tag || resync) begin
                  // Queue number travels in the top bits of tuser
                  pred   = int'(act.tuser[15:14]);
                  resync = 1'b0;
               end else begin
                  pred = next_busy_queue(ptr);
                  check_value("source queue", 64'(pred), 64'(act.tuser[15:14]));
               end
               cur_src = pred;
               in_pkt  = 1'b1;
            end
            checks++;
            assert (cur_src >= 0 && exp_q[cur_src].size() > 0) else begin
               $display("Output beat in test %s matches no accepted input beat", test_name);
               errors++;
            end
            if (cur_src >= 0 && exp_q[cur_src].size() > 0) begin
               exp = exp_q[cur_src].pop_front();
               check_value("beat", 64'(exp), 64'(act));
            end
            if (act.tlast) begin
               if (cur_src >= 0) begin
                  tlast_seen[cur_src]++;
                  ptr = (cur_src + 1) % NQ;
               end
               in_pkt = 1'b0;
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers entered on a rising edge
   //////////////////////////////////////////////////////////////////////

   function automatic int rand_len();
      logic [31:0] r;
      r = $random(seed);
      return 1 + int'(r % 3);
   endfunction

   function automatic logic rand_bit();
      logic [31:0] r;
      r = $random(seed);
      return r[0];
   endfunction

   task automatic send_packet(input int q, input int len, input int seq);
      axis_beat_t b;
      bit         accepted;
      for (int i = 0; i < len; i++) begin
         b.tdata = $random(seed);
         b.tstrb = $random(seed);
         b.tuser = {q[1:0], seq[5:0], i[7:0]};
         b.tlast = (i == len - 1);
         in_beat[q]  <= b;
         in_valid[q] <= 1'b1;
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge axi_aclk);
            accepted = s_ready[q];
            @(posedge axi_aclk);
         end
      end
      in_valid[q] <= 1'b0;
   endtask

   task automatic send_stream(input int q, input int n, input int seq0);
      for (int k = 0; k < n; k++) begin
         send_packet(q, rand_len(), seq0 + k);
      end
   endtask

   task automatic toggle_ready();
      while (!stream_done) begin
         @(posedge axi_aclk);
         m_axis_tready <= rand_bit();
      end
   endtask

   // Done once no beat is expected and the output has been quiet a while
   task automatic wait_drained();
      int idle;
      idle = 0;
      while (idle < 4) begin
         @(negedge axi_aclk);
         if (queues_empty() && !in_pkt && !m_tvalid) begin
            idle++;
         end else begin
            idle = 0;
         end
      end
      @(posedge axi_aclk);
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = errors;
      start_beats = beats_out;
   endtask

   task automatic end_test();
      $display("Test %s finished with %0d error(s)", test_name, errors - test_errors);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      repeat (10) @(posedge axi_aclk);
      axi_resetn <= 1'b1;
      @(posedge axi_aclk);

      begin_test("after_reset");
      @(negedge axi_aclk);
      check_value("m_axis_tvalid", 64'd0, 64'(m_tvalid));
      check_value("s_axis_tready", 64'hf, 64'(s_ready));
      check_counts();
      @(posedge axi_aclk);
      end_test();

      begin_test("single_packet");
      send_packet(2, 3, 0);
      wait_drained();
      check_value("beats out", 64'd3, 64'(beats_out - start_beats));
      end_test();

      // Load one packet per queue while stalled, then a second round
      begin_test("round_robin");
      m_axis_tready <= 1'b0;
      fork
         send_packet(0, rand_len(), 1);
         send_packet(1, rand_len(), 1);
         send_packet(2, rand_len(), 1);
         send_packet(3, rand_len(), 1);
      join
      resync = 1'b1;
      m_axis_tready <= 1'b1;
      fork
         send_packet(0, rand_len(), 2);
         send_packet(1, rand_len(), 2);
         send_packet(2, rand_len(), 2);
         send_packet(3, rand_len(), 2);
      join
      wait_drained();
      end_test();

      begin_test("back_pressure");
      follow_tag = 1'b1;
      m_axis_tready <= 1'b0;
      fork
         send_packet(0, 3, 3);
         send_packet(1, 3, 3);
         send_packet(2, 3, 3);
         send_packet(3, 3, 3);
      join
      @(negedge axi_aclk);
      for (int q = 0; q < NQ; q++) begin
         check_value("s_axis_tready with three held", 64'd0, 64'(s_ready[q]));
      end
      @(posedge axi_aclk);
      stream_done = 1'b0;
      fork
         toggle_ready();
         begin
            fork
               send_stream(0, 5, 10);
               send_stream(1, 5, 10);
               send_stream(2, 5, 10);
               send_stream(3, 5, 10);
            join
            stream_done = 1'b1;
         end
      join
      m_axis_tready <= 1'b1;
      wait_drained();
      follow_tag = 1'b0;
      end_test();

      begin_test("pkt_counters");
      @(negedge axi_aclk);
      check_counts();
      @(posedge axi_aclk);
      stats_clear <= 1'b1;
      @(posedge axi_aclk);
      stats_clear <= 1'b0;
      for (int q = 0; q < NQ; q++) begin
         tlast_seen[q] = 0;
      end
      @(negedge axi_aclk);
      check_counts();
      @(posedge axi_aclk);
      follow_tag = 1'b1;
      fork
         send_packet(0, rand_len(), 20);
         send_packet(1, rand_len(), 20);
         send_packet(2, rand_len(), 20);
         send_packet(3, rand_len(), 20);
      join
      wait_drained();
      follow_tag = 1'b0;
      @(negedge axi_aclk);
      check_counts();
      @(posedge axi_aclk);
      end_test();

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Watchdog limit well above the length of all tests together
   always @(posedge axi_aclk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, test %s never completed", cycles, test_name);
         $display("Errors found");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
source/arbiter_pkg.sv
source/small_fifo.sv
source/rr_arb_fsm.sv
source/pkt_counter.sv
source/input_arbiter.sv
testbench/tb_input_arbiter.sv

//--- run_sim.sh
#!/bin/sh
# Build the input arbiter testbench with Verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
   --top-module tb_input_arbiter -o tb_input_arbiter \
   && ./obj_dir/tb_input_arbiter > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^No errors$" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
